//--- src/omegaPkg.sv
`default_nettype none

// Shared widths, flit layout and network arithmetic for the omega fabric.
package omegaPkg;

  // Default port count of the fabric, overridden through module parameters.
  parameter int unsigned NumPorts = 8;

  // Default payload width in bits.
  parameter int unsigned DataWidth = 16;

  // Width of a port number, used for both destination and source index.
  parameter int unsigned PortIdxWidth = 3;

  // Bit offsets of the routing fields inside a flit.
  // The payload sits at the bottom, the source above it, the destination on top.
  parameter int unsigned SrcLsb = DataWidth;
  parameter int unsigned DestLsb = SrcLsb + PortIdxWidth;
  parameter int unsigned FlitWidth = DestLsb + PortIdxWidth;

  typedef logic [DataWidth-1:0] payloadT;
  typedef logic [PortIdxWidth-1:0] portIdxT;

  // One flit as it travels through the network.
  typedef logic [FlitWidth-1:0] flitT;

  // Number of switch levels for a radix-2 network.
  // Each level resolves one destination bit, so this is log2 of the port count.
  function automatic int unsigned NumLevels(int unsigned numPorts);
    return $clog2(numPorts);
  endfunction

  // Number of 2x2 switch elements in one level.
  function automatic int unsigned SwitchesPerLevel(int unsigned numPorts);
    return numPorts / 2;
  endfunction

endpackage

`default_nettype wire

//--- src/ingressPort.sv
`default_nettype none

// Input-side register stage for one fabric port.
// It takes a payload and a destination, tags them with its own port number
// and holds the resulting flit until the network accepts it.
module ingressPort #(
  parameter int unsigned NumPorts = omegaPkg::NumPorts,
  parameter int unsigned SrcIdx = 0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  omegaPkg::payloadT data_i,
  input  omegaPkg::portIdxT dest_i,
  output logic              valid_o,
  input  logic              ready_i,
  output omegaPkg::flitT    flit_o
);

  // Only the low log2(NumPorts) destination bits take part in routing.
  // Clearing the rest keeps a smaller fabric from steering on stale bits.
  localparam omegaPkg::portIdxT DestMask = omegaPkg::portIdxT'(NumPorts - 1);

  // The source tag is fixed per instance.
  localparam omegaPkg::portIdxT SrcTag = omegaPkg::portIdxT'(SrcIdx);

  logic           fullQ;
  omegaPkg::flitT flitQ;

  // The register can take a new flit when it is empty or is being emptied now.
  // This gives one flit per cycle with no bubble.
  assign ready_o = ~fullQ | ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fullQ <= 1'b0;
    end else if (ready_o) begin
      fullQ <= valid_i;
    end
  end

  // Payload register, loaded on every accepted transfer.
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      flitQ <= {dest_i & DestMask, SrcTag, data_i};
    end
  end

  assign valid_o = fullQ;
  assign flit_o = flitQ;

  // A sender that is kept waiting must hold its payload and destination.
  // The whole path to the output depends on the destination not moving.
  assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_i && !ready_o) |=> ($stable(data_i) && $stable(dest_i)))
    else $error("Ingress %0d: data or destination changed while stalled.", SrcIdx);

endmodule

`default_nettype wire

//--- src/omegaSwitch.sv
`default_nettype none

// Radix-2 switch element of the omega network.
// Each of the two outputs has its own round-robin arbiter over the two inputs.
// The data path is combinational; only the arbiter state is registered.
module omegaSwitch (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic           [1:0] valid_i,
  output logic           [1:0] ready_o,
  input  omegaPkg::flitT [1:0] flit_i,
  input  logic           [1:0] sel_i,
  output logic           [1:0] valid_o,
  input  logic           [1:0] ready_i,
  output omegaPkg::flitT [1:0] flit_o
);

  // Request matrix, indexed as req[output][input].
  logic [1:0][1:0] req;

  // Input currently granted by each output.
  logic [1:0] gntIdx;

  // Preferred input of each output for the next free arbitration.
  logic [1:0] rrPtrQ;

  // A set lock bit pins the grant of that output to lockIdxQ.
  logic [1:0] lockQ;
  logic [1:0] lockIdxQ;

  // An input requests the output that its routing bit names.
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int k = 0; k < 2; k++) begin
        req[o][k] = valid_i[k] && (sel_i[k] == 1'(o));
      end
    end
  end

  // Grant selection and output mux.
  // A locked output keeps its previous winner.
  // Otherwise the pointer input wins if it requests, and the other input gets the turn
  // when it does not.
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      if (lockQ[o]) begin
        gntIdx[o] = lockIdxQ[o];
      end else if (req[o][rrPtrQ[o]]) begin
        gntIdx[o] = rrPtrQ[o];
      end else begin
        gntIdx[o] = ~rrPtrQ[o];
      end
      valid_o[o] = req[o][gntIdx[o]];
      flit_o[o] = flit_i[gntIdx[o]];
    end
  end

  // An input sees the ready of the output it addresses, but only while it holds that grant.
  // The loser of an arbitration therefore waits with its flit unchanged.
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      ready_o[k] = ready_i[sel_i[k]] && (gntIdx[sel_i[k]] == 1'(k));
    end
  end

  // Arbiter state update.
  // A completed transfer releases the lock and moves the pointer past the winner.
  // A stalled transfer locks the grant so the output flit cannot switch sources.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rrPtrQ <= '0;
      lockQ <= '0;
      lockIdxQ <= '0;
    end else begin
      for (int o = 0; o < 2; o++) begin
        if (valid_o[o]) begin
          if (ready_i[o]) begin
            lockQ[o] <= 1'b0;
            rrPtrQ[o] <= ~gntIdx[o];
          end else begin
            lockQ[o] <= 1'b1;
            lockIdxQ[o] <= gntIdx[o];
          end
        end
      end
    end
  end

  // The output flit of a stalled transfer must not move.
  // This holds only if the lock works and the upstream stage keeps its flit as well.
  for (genvar o = 0; o < 2; o++) begin : genStableOut
    assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_o[o] && !ready_i[o]) |=> $stable(flit_o[o]))
      else $error("Switch output %0d changed its flit while stalled.", o);
  end

endmodule

`default_nettype wire

//--- src/omegaNetwork.sv
`default_nettype none

// Omega network of radix-2 switch elements.
// Level 0 takes the inputs in reverse order, the levels are joined by a perfect shuffle
// and the last level drives the outputs in order.
// Level i routes on destination bit (NumLevels-1-i), most significant bit first.
module omegaNetwork #(
  parameter int unsigned NumPorts = omegaPkg::NumPorts
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic           [NumPorts-1:0] valid_i,
  output logic           [NumPorts-1:0] ready_o,
  input  omegaPkg::flitT [NumPorts-1:0] flit_i,
  output logic           [NumPorts-1:0] valid_o,
  input  logic           [NumPorts-1:0] ready_i,
  output omegaPkg::flitT [NumPorts-1:0] flit_o
);

  localparam int unsigned NumLevels = omegaPkg::NumLevels(NumPorts);
  localparam int unsigned NumSwitches = omegaPkg::SwitchesPerLevel(NumPorts);

  // Lane l of a level is port (l % 2) of switch (l / 2).
  // The "in" arrays face the switch inputs and the "out" arrays the switch outputs.
  omegaPkg::flitT [NumLevels-1:0][NumPorts-1:0] inFlit;
  logic           [NumLevels-1:0][NumPorts-1:0] inValid;
  logic           [NumLevels-1:0][NumPorts-1:0] inReady;
  omegaPkg::flitT [NumLevels-1:0][NumPorts-1:0] outFlit;
  logic           [NumLevels-1:0][NumPorts-1:0] outValid;
  logic           [NumLevels-1:0][NumPorts-1:0] outReady;

  // Level 0 gets the external inputs in reverse order.
  for (genvar l = 0; l < NumPorts; l++) begin : genInputs
    assign inFlit[0][l] = flit_i[NumPorts-1-l];
    assign inValid[0][l] = valid_i[NumPorts-1-l];
    assign ready_o[NumPorts-1-l] = inReady[0][l];
  end

  // Perfect shuffle between levels.
  // Output lane l goes to switch (l % NumSwitches), port (l / NumSwitches) of the next level.
  // In lane numbers this is a rotate left of the lane index.
  for (genvar i = 0; i < NumLevels - 1; i++) begin : genShuffle
    for (genvar l = 0; l < NumPorts; l++) begin : genLane
      localparam int unsigned DstLane = 2 * (l % NumSwitches) + l / NumSwitches;
      assign inFlit[i+1][DstLane] = outFlit[i][l];
      assign inValid[i+1][DstLane] = outValid[i][l];
      assign outReady[i][l] = inReady[i+1][DstLane];
    end
  end

  // Switch elements, each steered by one destination bit of its two input flits.
  for (genvar i = 0; i < NumLevels; i++) begin : genLevel
    localparam int unsigned SelBit = omegaPkg::DestLsb + NumLevels - 1 - i;
    for (genvar j = 0; j < NumSwitches; j++) begin : genSwitch
      logic [1:0] sel;
      assign sel = {inFlit[i][2*j+1][SelBit], inFlit[i][2*j][SelBit]};

      omegaSwitch uSwitch (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (inValid[i][2*j +: 2]),
        .ready_o (inReady[i][2*j +: 2]),
        .flit_i  (inFlit[i][2*j +: 2]),
        .sel_i   (sel),
        .valid_o (outValid[i][2*j +: 2]),
        .ready_i (outReady[i][2*j +: 2]),
        .flit_o  (outFlit[i][2*j +: 2])
      );
    end
  end

  // The last level lands each flit on the lane equal to its destination.
  assign flit_o = outFlit[NumLevels-1];
  assign valid_o = outValid[NumLevels-1];
  assign outReady[NumLevels-1] = ready_i;

  // Destination-tag routing with radix-2 switches needs a power-of-two port count.
  initial begin
    assert ((NumPorts >= 2) && ((2 ** $clog2(NumPorts)) == NumPorts))
      else $fatal(1, "NumPorts %0d is not a power of two of at least 2.", NumPorts);
  end

endmodule

`default_nettype wire

//--- src/egressPort.sv
`default_nettype none

// Output-side spill register for one fabric port.
// Two entries let it take a flit every cycle while its ready_o comes from flops only,
// which cuts the combinational ready path back through the network.
// The destination is dropped on entry since the port number already implies it.
module egressPort (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  omegaPkg::flitT    flit_i,
  output logic              valid_o,
  input  logic              ready_i,
  output omegaPkg::payloadT data_o,
  output omegaPkg::portIdxT src_o
);

  // Everything below the destination field is kept, that is source and payload.
  localparam int unsigned KeepWidth = omegaPkg::DestLsb;

  // Entry A takes new flits and entry B holds a flit that could not leave in time.
  logic                 aFullQ;
  logic                 bFullQ;
  logic [KeepWidth-1:0] aQ;
  logic [KeepWidth-1:0] bQ;
  logic [KeepWidth-1:0] headFlit;
  logic                 aFill;
  logic                 aDrain;
  logic                 bFill;
  logic                 bDrain;

  // A is refilled on every accepted input.
  assign aFill = valid_i && ready_o;

  // A empties whenever B is free, either to the output or into B.
  assign aDrain = aFullQ && !bFullQ;

  // B catches the flit of A only when the output stalls.
  assign bFill = aDrain && !ready_i;
  assign bDrain = bFullQ && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aFullQ <= 1'b0;
      bFullQ <= 1'b0;
    end else begin
      if (aFill || aDrain) begin
        aFullQ <= aFill;
      end
      if (bFill || bDrain) begin
        bFullQ <= bFill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aFill) begin
      aQ <= flit_i[KeepWidth-1:0];
    end
    if (bFill) begin
      bQ <= aQ;
    end
  end

  // B is always older than A, so it goes first when full.
  assign headFlit = bFullQ ? bQ : aQ;

  assign ready_o = !aFullQ || !bFullQ;
  assign valid_o = aFullQ || bFullQ;
  assign data_o = headFlit[omegaPkg::DataWidth-1:0];
  assign src_o = headFlit[omegaPkg::SrcLsb +: omegaPkg::PortIdxWidth];

  // The downstream sink must see an unchanged flit until it takes it.
  assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> ($stable(data_o) && $stable(src_o)))
    else $error("Egress output changed data or source while stalled.");

endmodule

`default_nettype wire

//--- src/omegaFabric.sv
`default_nettype none

// Packet-switching fabric built around a radix-2 omega network.
// Flits are registered once on the way in and once on the way out, for a latency of two
// cycles through an idle fabric.
module omegaFabric #(
  parameter int unsigned NumPorts = omegaPkg::NumPorts,
  parameter int unsigned DataWidth = omegaPkg::DataWidth
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic [NumPorts-1:0]                      valid_i,
  output logic [NumPorts-1:0]                      ready_o,
  input  logic [NumPorts*DataWidth-1:0]            data_i,
  input  logic [NumPorts*omegaPkg::PortIdxWidth-1:0] dest_i,
  output logic [NumPorts-1:0]                      valid_o,
  input  logic [NumPorts-1:0]                      ready_i,
  output logic [NumPorts*DataWidth-1:0]            data_o,
  output logic [NumPorts*omegaPkg::PortIdxWidth-1:0] src_o
);

  localparam int unsigned IdxW = omegaPkg::PortIdxWidth;

  // Links between the ingress stages and the network.
  omegaPkg::flitT [NumPorts-1:0] ingFlit;
  logic           [NumPorts-1:0] ingValid;
  logic           [NumPorts-1:0] ingReady;

  // Links between the network and the egress stages.
  omegaPkg::flitT [NumPorts-1:0] egFlit;
  logic           [NumPorts-1:0] egValid;
  logic           [NumPorts-1:0] egReady;

  for (genvar p = 0; p < NumPorts; p++) begin : genIngress
    ingressPort #(
      .NumPorts (NumPorts),
      .SrcIdx   (p)
    ) uIngress (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (valid_i[p]),
      .ready_o (ready_o[p]),
      .data_i  (data_i[p*DataWidth +: DataWidth]),
      .dest_i  (dest_i[p*IdxW +: IdxW]),
      .valid_o (ingValid[p]),
      .ready_i (ingReady[p]),
      .flit_o  (ingFlit[p])
    );
  end

  omegaNetwork #(
    .NumPorts (NumPorts)
  ) uNetwork (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (ingValid),
    .ready_o (ingReady),
    .flit_i  (ingFlit),
    .valid_o (egValid),
    .ready_i (egReady),
    .flit_o  (egFlit)
  );

  for (genvar p = 0; p < NumPorts; p++) begin : genEgress
    egressPort uEgress (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (egValid[p]),
      .ready_o (egReady[p]),
      .flit_i  (egFlit[p]),
      .valid_o (valid_o[p]),
      .ready_i (ready_i[p]),
      .data_o  (data_o[p*DataWidth +: DataWidth]),
      .src_o   (src_o[p*IdxW +: IdxW])
    );
  end

endmodule

`default_nettype wire

//--- testbench/tbOmegaFabric.sv
`default_nettype none

// Testbench for the omega fabric.
// Stimulus rows and expected per-output counts come from testbench/omega_input.txt.
// Every accepted flit goes onto a scoreboard keyed by source and destination, and
// every delivered flit must match the oldest open entry of its pair.
module tbOmegaFabric;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP = omegaPkg::NumPorts;
  localparam int DW = omegaPkg::DataWidth;
  localparam int IW = omegaPkg::PortIdxWidth;
  localparam int MaxTests = 8;
  localparam int MaxRows = 64;

  logic             clk;
  logic             rst;
  logic [NP-1:0]    validIn;
  logic [NP-1:0]    readyOut;
  logic [NP*DW-1:0] dataIn;
  logic [NP*IW-1:0] destIn;
  logic [NP-1:0]    validOut;
  logic [NP-1:0]    readyIn;
  logic [NP*DW-1:0] dataOut;
  logic [NP*IW-1:0] srcOut;

  // Test table as loaded from the data file.
  // Each row sends one flit from every source, with payload base + source.
  int numTests;
  int numRows;
  int testId[MaxTests];
  int bpPct[MaxTests];
  int serialMode[MaxTests];
  int rowFirst[MaxTests];
  int rowNum[MaxTests];
  int expCnt[MaxTests][NP];
  omegaPkg::payloadT rowBase[MaxRows];
  omegaPkg::portIdxT rowDest[MaxRows][NP];

  // Scoreboard FIFOs, one per pair, indexed as source * NP + destination.
  omegaPkg::payloadT expMem[NP*NP][MaxRows];
  int wrIdx[NP*NP];
  int rdIdx[NP*NP];

  int errCount;
  int passTests;
  int failTests;
  int cycle;
  bit loadOk;
  bit loadDone;
  integer seed = 32'h1b7684a6;

  omegaFabric #(
    .NumPorts  (NP),
    .DataWidth (DW)
  ) dut (
    .clk_i   (clk),
    .rst_i   (rst),
    .valid_i (validIn),
    .ready_o (readyOut),
    .data_i  (dataIn),
    .dest_i  (destIn),
    .valid_o (validOut),
    .ready_i (readyIn),
    .data_o  (dataOut),
    .src_o   (srcOut)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errCount++;
    end
  endtask

  // The file opens with two comment lines, then holds whitespace-separated fields.
  task automatic loadStimulus();
    int fd;
    int n;
    string line;
    fd = $fopen("testbench/omega_input.txt", "r");
    loadOk = (fd != 0);
    numTests = 0;
    numRows = 0;
    if (!loadOk) begin
      $display("Cannot open the stimulus file testbench/omega_input.txt.");
    end else begin
      void'($fgets(line, fd));
      void'($fgets(line, fd));
      while ($fscanf(fd, "%d %d %d %d", testId[numTests], bpPct[numTests],
                     serialMode[numTests], rowNum[numTests]) == 4) begin
        rowFirst[numTests] = numRows;
        n = 0;
        for (int k = 0; k < rowNum[numTests]; k++) begin
          n += $fscanf(fd, "%h", rowBase[numRows]);
          for (int d = 0; d < NP; d++) begin
            n += $fscanf(fd, "%d", rowDest[numRows][d]);
          end
          numRows++;
        end
        for (int o = 0; o < NP; o++) begin
          n += $fscanf(fd, "%d", expCnt[numTests][o]);
        end
        if (n != rowNum[numTests] * (NP + 1) + NP) begin
          $display("Test %0d in the stimulus file is incomplete.", testId[numTests]);
          loadOk = 1'b0;
        end
        numTests++;
      end
      $fclose(fd);
    end
  endtask

  task automatic runTest(input int t);
    int ptr[NP];
    int gotCnt[NP];
    logic [NP-1:0] stallPrev;
    omegaPkg::payloadT dataPrev[NP];
    omegaPkg::portIdxT srcPrev[NP];
    omegaPkg::portIdxT src;
    int r;
    int pair;
    int sent;
    int recv;
    int total;
    int errStart;
    int fireCycle;
    total = rowNum[t] * NP;
    sent = 0;
    recv = 0;
    errStart = errCount;
    fireCycle = 0;
    stallPrev = '0;
    for (int k = 0; k < NP * NP; k++) begin
      wrIdx[k] = 0;
      rdIdx[k] = 0;
    end
    for (int s = 0; s < NP; s++) begin
      ptr[s] = 0;
      gotCnt[s] = 0;
    end
    while (recv < total) begin
      @(negedge clk);
      cycle++;
      for (int o = 0; o < NP; o++) begin
        readyIn[o] = (($random(seed) & 32'h7fffffff) % 100) >= bpPct[t];
      end
      // A source offers its next row until it is taken.
      // In serial mode only one flit is in the fabric at any time.
      for (int s = 0; s < NP; s++) begin
        validIn[s] = (ptr[s] < rowNum[t]) &&
                     (!serialMode[t] || (s == sent % NP && recv == sent));
        if (validIn[s]) begin
          r = rowFirst[t] + ptr[s];
          dataIn[s*DW +: DW] = rowBase[r] + s;
          destIn[s*IW +: IW] = rowDest[r][s];
        end
      end
      // Sample after the inputs settle; these handshakes complete on the next rising edge.
      #1;
      for (int s = 0; s < NP; s++) begin
        if (validIn[s] && readyOut[s]) begin
          r = rowFirst[t] + ptr[s];
          pair = s * NP + rowDest[r][s];
          expMem[pair][wrIdx[pair]] = rowBase[r] + s;
          wrIdx[pair]++;
          ptr[s]++;
          sent++;
          fireCycle = cycle;
        end
      end
      for (int o = 0; o < NP; o++) begin
        // A stalled output must present the very same flit again.
        if (stallPrev[o]) begin
          checkValue($sformatf("valid_o[%0d]", o), validOut[o], 1);
          checkValue($sformatf("data_o[%0d]", o), dataOut[o*DW +: DW], dataPrev[o]);
          checkValue($sformatf("src_o[%0d]", o), srcOut[o*IW +: IW], srcPrev[o]);
        end
        if (validOut[o] && readyIn[o]) begin
          src = srcOut[o*IW +: IW];
          pair = src * NP + o;
          if (rdIdx[pair] < wrIdx[pair]) begin
            checkValue($sformatf("data_o[%0d]", o), dataOut[o*DW +: DW], expMem[pair][rdIdx[pair]]);
            rdIdx[pair]++;
          end else begin
            $display("Output %0d delivered a flit from source %0d that was never sent there.",
                     o, src);
            errCount++;
          end
          // Input handshake to output handshake takes two cycles in an idle fabric.
          if (serialMode[t]) begin
            checkValue($sformatf("latency to output %0d", o), cycle - fireCycle, 2);
          end
          gotCnt[o]++;
          recv++;
        end
        stallPrev[o] = validOut[o] && !readyIn[o];
        dataPrev[o] = dataOut[o*DW +: DW];
        srcPrev[o] = srcOut[o*IW +: IW];
      end
    end
    // Nothing may show up after the last expected flit.
    // A flit that was stalled in the last sample stays visible until ready rises.
    repeat (3) begin
      @(negedge clk);
      validIn = '0;
      readyIn = '1;
      #1;
      if (validOut != '0) begin
        $display("An output still shows a flit after all expected flits were delivered.");
        errCount++;
      end
    end
    for (int o = 0; o < NP; o++) begin
      checkValue($sformatf("flit count at output %0d", o), gotCnt[o], expCnt[t][o]);
    end
    if (errCount == errStart) begin
      passTests++;
    end else begin
      failTests++;
    end
    $display("Test %0d finished: %0d flits, %0d%% back-pressure, %0d errors", testId[t], total,
             bpPct[t], errCount - errStart);
  endtask

  // Allows 50 cycles per flit plus 200 per test.
  initial begin : watchdog
    int limit;
    wait (loadDone);
    limit = 0;
    for (int t = 0; t < numTests; t++) begin
      limit += rowNum[t] * NP * 50 + 200;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles.", limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    validIn = '0;
    dataIn = '0;
    destIn = '0;
    readyIn = '1;
    rst = 1'b1;
    errCount = 0;
    passTests = 0;
    failTests = 0;
    cycle = 0;
    loadDone = 1'b0;
    loadStimulus();
    loadDone = 1'b1;
    if (loadOk) begin
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      #1;
      // All stages are empty after reset.
      checkValue("ready_o", readyOut, {NP{1'b1}});
      checkValue("valid_o", validOut, 0);
      for (int t = 0; t < numTests; t++) begin
        runTest(t);
      end
    end
    $display("Summary: %0d tests passed, %0d tests failed", passTests, failTests);
    if (loadOk && errCount == 0 && failTests == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/omega_input.txt
# Test header: test number, back-pressure percent, serial flag, row count; rows follow.
# Row: hex payload base, destinations of sources 0..7. Last line: flit counts at outputs 0..7.
1 0 1 8
0100 0 1 2 3 4 5 6 7
0110 1 2 3 4 5 6 7 0
0120 2 3 4 5 6 7 0 1
0130 3 4 5 6 7 0 1 2
0140 4 5 6 7 0 1 2 3
0150 5 6 7 0 1 2 3 4
0160 6 7 0 1 2 3 4 5
0170 7 0 1 2 3 4 5 6
8 8 8 8 8 8 8 8
2 0 0 3
0200 0 1 2 3 4 5 6 7
0210 0 4 2 6 1 5 3 7
0220 1 2 3 4 5 6 7 0
3 3 3 3 3 3 3 3
3 0 0 4
0300 3 3 3 3 3 3 3 3
0310 3 3 3 3 3 3 3 3
0320 3 3 3 3 3 3 3 3
0330 3 3 3 3 3 3 3 3
0 0 0 32 0 0 0 0
4 40 0 6
0400 5 2 7 0 3 3 6 1
0410 0 0 4 6 2 7 5 1
0420 7 1 1 3 6 4 2 5
0430 2 6 0 5 5 1 7 4
0440 4 3 6 2 0 7 1 1
0450 1 5 3 7 4 0 0 6
7 8 5 5 5 6 6 6
5 70 0 3
0500 6 6 6 6 1 1 1 1
0510 2 2 5 5 2 2 5 5
0520 7 4 7 4 0 0 3 3
2 4 4 2 2 4 4 2

//--- tb.f
src/omegaPkg.sv
src/ingressPort.sv
src/omegaSwitch.sv
src/omegaNetwork.sv
src/egressPort.sv
src/omegaFabric.sv
testbench/tbOmegaFabric.sv

//--- Bender.yml
package:
  name: omega_fabric

sources:
  - files:
      - src/omegaPkg.sv
      - src/ingressPort.sv
      - src/omegaSwitch.sv
      - src/omegaNetwork.sv
      - src/egressPort.sv
      - src/omegaFabric.sv
  - target: simulation
    files:
      - testbench/tbOmegaFabric.sv
